//--- sources.f
source/mem_cfg_pkg.sv
source/isa_pkg.sv
source/instr_port.sv
source/line_builder.sv
source/line_ram.sv
source/fma_feed.sv
source/memory_unit.sv
verif/tb_pkg.sv
verif/tb_memory_unit.sv

//--- Makefile
TOP := tb_memory_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o sim_$(TOP)

# the run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- verif/tb_memory_unit.sv
module tb_memory_unit;

    localparam int CLK_HALF   = 10;
    localparam int MAX_CYCLES = 4000; // 5 tests x 30 instructions x 6 cycles, rounded up

    logic                    clk_in;
    logic                    rst_in;
    isa_pkg::instr_t         instr;
    logic                    instr_req;
    logic                    instr_ack;
    mem_cfg_pkg::ctrl_regs_t regs;
    mem_cfg_pkg::line_t      wb_line;
    mem_cfg_pkg::line_t      abc_out;
    mem_cfg_pkg::fma_flags_t flags_out;
    logic                    abc_valid;

    mem_cfg_pkg::line_t      stage_model;  // what the staging line should hold
    mem_cfg_pkg::line_t      ram_model [mem_cfg_pkg::LINE_DEPTH];
    mem_cfg_pkg::line_addr_t addr_model;   // address kept between instructions
    mem_cfg_pkg::line_t      exp_line;     // expected with the next abc_valid pulse
    mem_cfg_pkg::fma_flags_t exp_flags;
    logic                    out_live = 1'b0; // set once abc_out carries a real line
    logic [15:0]             lfsr_state;
    mem_cfg_pkg::word_t      pick;
    mem_cfg_pkg::word_t      keep_addr;
    int                      flag_vals [3] = '{0, 1, 5};
    int                      errors = 0;
    int                      err_mark = 0;
    int                      tests_passed = 0;
    int                      tests_failed = 0;
    int                      cycles = 0;
    int                      pulses = 0; // abc_valid pulses seen so far

    memory_unit u_dut (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .instr     (instr),
        .instr_req (instr_req),
        .instr_ack (instr_ack),
        .regs      (regs),
        .wb_line   (wb_line),
        .abc_out   (abc_out),
        .flags_out (flags_out),
        .abc_valid (abc_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #CLK_HALF clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // the pulse of a WRITEB is over before its handshake has ended
    always @(posedge clk_in) begin
        if (abc_valid) begin
            pulses <= pulses + 1;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    reset_state: assert property (@(posedge clk_in)
        rst_in |=> (!instr_ack && !abc_valid && flags_out == '0))
        else begin
            errors++;
            $display("error %0t: outputs not low after reset", $time);
        end

    ack_rise: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(instr_ack) |-> $past(instr_req))
        else begin
            errors++;
            $display("error %0t: ack rose without a request", $time);
        end

    ack_fall: assert property (@(posedge clk_in) disable iff (rst_in)
        $fell(instr_ack) |-> !$past(instr_req))
        else begin
            errors++;
            $display("error %0t: ack fell while req was high", $time);
        end

    // the pulse comes two cycles after the ack of a WRITEB and lasts one cycle
    valid_timing: assert property (@(posedge clk_in) disable iff (rst_in)
        abc_valid == ($past(instr_ack, 2) && !$past(instr_ack, 3)
                      && $past(instr[31:28], 3) == isa_pkg::WRITEB))
        else begin
            errors++;
            $display("error %0t: abc_valid pulse out of place", $time);
        end

    line_value: assert property (@(posedge clk_in) disable iff (rst_in)
        abc_valid |-> abc_out == exp_line)
        else begin
            errors++;
            $display("error %0t: abc_out %h, expected %h", $time, abc_out, exp_line);
        end

    flag_value: assert property (@(posedge clk_in) disable iff (rst_in)
        abc_valid |-> flags_out == exp_flags)
        else begin
            errors++;
            $display("error %0t: flags_out %b, expected %b", $time, flags_out, exp_flags);
        end

    output_hold: assert property (@(posedge clk_in) disable iff (rst_in || !out_live)
        !abc_valid |-> ($stable(abc_out) && $stable(flags_out)))
        else begin
            errors++;
            $display("error %0t: outputs moved between WRITEBs", $time);
        end

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------

    function automatic logic [95:0] take_bits(input int n);
        logic [95:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = tb_pkg::lfsr_next(lfsr_state);
            v = {v[94:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic mem_cfg_pkg::word_t rand_word();
        return mem_cfg_pkg::word_t'(take_bits(16));
    endfunction

    // four-phase exchange, returns once ack is low again
    task automatic issue(input isa_pkg::instr_t word);
        @(posedge clk_in);
        instr     <= word;
        instr_req <= 1'b1;
        @(posedge clk_in);
        while (!instr_ack) @(posedge clk_in);
        instr_req <= 1'b0;
        @(posedge clk_in);
        while (instr_ack) @(posedge clk_in);
    endtask

    task automatic set_addr(input mem_cfg_pkg::word_t imm);
        issue(tb_pkg::encode(isa_pkg::SMA, '0, imm, '0));
        addr_model = mem_cfg_pkg::line_addr_t'(imm); // only the low 9 bits address a line
    endtask

    task automatic alu_op(input isa_pkg::opcode_e op, input mem_cfg_pkg::word_t imm);
        issue(tb_pkg::encode(op, 4'hF, imm, 4'hF));
    endtask

    task automatic put_imm(input int idx, input mem_cfg_pkg::word_t val);
        issue(tb_pkg::encode(isa_pkg::LOADI, isa_pkg::field_t'(idx), val, '0));
        stage_model = tb_pkg::put_word(stage_model, idx, val);
    endtask

    task automatic load_step(input int slot, input int sel, input mem_cfg_pkg::word_t diff);
        issue(tb_pkg::encode(isa_pkg::LOAD, isa_pkg::field_t'(slot), diff,
                             isa_pkg::field_t'(sel)));
        stage_model = tb_pkg::load_slots(stage_model, slot,
                                         tb_pkg::pick_reg(regs, isa_pkg::field_t'(sel)), diff);
    endtask

    task automatic send_line();
        issue(tb_pkg::encode(isa_pkg::SENDL, '0, '0, '0));
        ram_model[addr_model] = stage_model;
    endtask

    task automatic store_buffer(input mem_cfg_pkg::word_t imm);
        issue(tb_pkg::encode(isa_pkg::LOADB, '0, imm, '0));
        addr_model = mem_cfg_pkg::line_addr_t'(imm);
        ram_model[addr_model] = wb_line;
    endtask

    // expected values are set long before the pulse they are compared with
    task automatic read_out(input mem_cfg_pkg::word_t imm, input int fa, input int fb);
        int mark;
        mark       = pulses;
        addr_model = mem_cfg_pkg::line_addr_t'(imm);
        exp_line   = ram_model[addr_model];
        exp_flags  = tb_pkg::flags_for(isa_pkg::field_t'(fa), isa_pkg::field_t'(fb));
        issue(tb_pkg::encode(isa_pkg::WRITEB, isa_pkg::field_t'(fa), imm,
                             isa_pkg::field_t'(fb)));
        while (pulses == mark) @(posedge clk_in);
        out_live = 1'b1;
    endtask

    task automatic close_test(input string name);
        repeat (2) @(posedge clk_in); // assertions of the last instruction report first
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------

    initial begin
        rst_in      = 1'b1;
        instr       = '0;
        instr_req   = 1'b0;
        regs        = '0;
        wb_line     = '0;
        lfsr_state  = tb_pkg::LFSR_SEED;
        stage_model = '0;
        addr_model  = '0;
        repeat (3) @(posedge clk_in);
        rst_in <= 1'b0;

        // ALU opcodes must leave both the staging line and the address alone
        set_addr(16'h0003);
        put_imm(2, 16'h1234);
        alu_op(isa_pkg::XOR, 16'h0007);
        alu_op(isa_pkg::JUMP, 16'h0009);
        send_line();
        read_out(16'h0003, 0, 0);
        close_test("reset and handshake");

        for (int r = 0; r < 3; r++) begin
            pick = rand_word();
            set_addr(pick);
            for (int k = 0; k < 6; k++) begin
                put_imm(k, rand_word());
            end
            put_imm(6 + int'(take_bits(3)), rand_word()); // out of range, line unchanged
            send_line();
            read_out(pick, 0, 0);
        end
        close_test("loadi, sendl and writeb");

        for (int r = 0; r < 4; r++) begin
            @(posedge clk_in);
            regs <= {rand_word(), rand_word(), rand_word()};
            pick = rand_word();
            set_addr(pick);
            for (int n = 0; n < 3; n++) begin
                load_step(int'(take_bits(2)), int'(take_bits(2)), rand_word());
            end
            send_line();
            read_out(pick, 0, 0);
        end
        keep_addr = pick;
        close_test("load");

        @(posedge clk_in);
        wb_line <= {rand_word(), rand_word(), rand_word(), rand_word(), rand_word(), rand_word()};
        pick = rand_word();
        if (mem_cfg_pkg::line_addr_t'(pick) == mem_cfg_pkg::line_addr_t'(keep_addr)) begin
            pick = pick ^ 16'h0001;
        end
        store_buffer(pick);
        read_out(pick, 0, 0);
        read_out(keep_addr, 0, 0); // the older line must still be there
        close_test("loadb");

        for (int a = 0; a < 3; a++) begin
            for (int b = 0; b < 3; b++) begin
                read_out(keep_addr, flag_vals[a], flag_vals[b]);
                alu_op(isa_pkg::NOP, 16'h0000); // gap in which the flags must hold
            end
        end
        close_test("writeb flags");

        $display("tests passed %0d, failed %0d, assertion errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verif/tb_pkg.sv
package tb_pkg;

    // --------------------------------------------------
    // random numbers
    // --------------------------------------------------

    localparam logic [15:0] LFSR_SEED = 16'd813;
    localparam logic [15:0] LFSR_TAPS = 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1

    // one step of a right-shifting Galois LFSR, the caller takes bit 0 afterwards
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // --------------------------------------------------
    // instruction encoder and reference model
    // --------------------------------------------------

    // opcode, field_a, imm, field_b from the top down, low nibble left at zero
    function automatic isa_pkg::instr_t encode(input isa_pkg::opcode_e   op,
                                               input isa_pkg::field_t    field_a,
                                               input mem_cfg_pkg::word_t imm,
                                               input isa_pkg::field_t    field_b);
        return {op, field_a, imm, field_b, 4'h0};
    endfunction

    // word k counts down from the top of the line, indices past the last word change nothing
    function automatic mem_cfg_pkg::line_t put_word(input mem_cfg_pkg::line_t l,
                                                    input int k,
                                                    input mem_cfg_pkg::word_t w);
        mem_cfg_pkg::line_t r;
        r = l;
        if (k >= 0 && k < mem_cfg_pkg::WORDS_PER_LINE) begin
            r[mem_cfg_pkg::LINE_WIDTH - 16 * (k + 1) +: 16] = w;
        end
        return r;
    endfunction

    // each FMA gets one more diff than the FMA before it, slot 3 and up is ignored
    function automatic mem_cfg_pkg::line_t load_slots(input mem_cfg_pkg::line_t l,
                                                      input int slot,
                                                      input mem_cfg_pkg::word_t base,
                                                      input mem_cfg_pkg::word_t diff);
        mem_cfg_pkg::line_t r;
        mem_cfg_pkg::word_t step;
        r    = l;
        step = base; // wraps at 16 bits like the FMA operands
        if (slot < 3) begin
            for (int i = 0; i < 2; i++) begin
                r    = put_word(r, 3 * i + slot, step);
                step = step + diff;
            end
        end
        return r;
    endfunction

    function automatic mem_cfg_pkg::word_t pick_reg(input mem_cfg_pkg::ctrl_regs_t regs,
                                                    input isa_pkg::field_t sel);
        case (sel)
            4'd0:    return regs.reg_a;
            4'd1:    return regs.reg_b;
            default: return regs.reg_c; // every other select lands on reg_c
        endcase
    endfunction

    function automatic mem_cfg_pkg::fma_flags_t flags_for(input isa_pkg::field_t fa,
                                                          input isa_pkg::field_t fb);
        mem_cfg_pkg::fma_flags_t f;
        f.use_new_c = (fa == 4'd1);
        f.fma_valid = (fb == 4'd1);
        return f;
    endfunction

endpackage

//--- source/memory_unit.sv
module memory_unit (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  isa_pkg::instr_t         instr,
    input  logic                    instr_req,
    output logic                    instr_ack,
    input  mem_cfg_pkg::ctrl_regs_t regs,
    input  mem_cfg_pkg::line_t      wb_line,
    output mem_cfg_pkg::line_t      abc_out,
    output mem_cfg_pkg::fma_flags_t flags_out,
    output logic                    abc_valid
);

    // --------------------------------------------------
    // internal nets
    // --------------------------------------------------

    isa_pkg::mem_cmd_t       cmd;        // decoded instruction, valid with cmd_strobe
    logic                    cmd_strobe;

    logic                    wr_en;      // builder to RAM
    mem_cfg_pkg::line_addr_t wr_addr;
    mem_cfg_pkg::line_t      wr_line;

    logic                    rd_en;      // feed to RAM and back
    mem_cfg_pkg::line_addr_t rd_addr;
    mem_cfg_pkg::line_t      rd_line;

    // --------------------------------------------------
    // instances
    // --------------------------------------------------

    instr_port u_port (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .instr      (instr),
        .instr_req  (instr_req),
        .instr_ack  (instr_ack),
        .regs       (regs),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe)
    );

    // staging line and the write path into the RAM
    line_builder u_builder (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .wb_line    (wb_line),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_line    (wr_line)
    );

    line_ram u_ram (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_line (wr_line),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_line (rd_line)
    );

    // read path toward the two FMAs
    fma_feed u_feed (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_line    (rd_line),
        .abc_out    (abc_out),
        .flags_out  (flags_out),
        .abc_valid  (abc_valid)
    );

endmodule

//--- source/fma_feed.sv
module fma_feed (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  isa_pkg::mem_cmd_t       cmd,
    input  logic                    cmd_strobe,
    output logic                    rd_en,
    output mem_cfg_pkg::line_addr_t rd_addr,
    input  mem_cfg_pkg::line_t      rd_line,
    output mem_cfg_pkg::line_t      abc_out,
    output mem_cfg_pkg::fma_flags_t flags_out,
    output logic                    abc_valid
);

    logic                    ram_valid; // a read is sitting in the RAM output stage
    mem_cfg_pkg::fma_flags_t ram_flags; // flags of that read

    // --------------------------------------------------
    // read issue
    // --------------------------------------------------

    // WRITEB reads in its strobe cycle, the RAM registers the line on the next edge
    assign rd_en   = cmd_strobe && (cmd.op == isa_pkg::WRITEB);
    assign rd_addr = cmd.addr;

    // flags ride beside the RAM stage so each read keeps its own
    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            ram_flags <= cmd.flags;
        end
    end

    // --------------------------------------------------
    // output stage toward the FMAs
    // --------------------------------------------------

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ram_valid <= 1'b0;
            abc_valid <= 1'b0;
            flags_out <= '0;
        end else begin
            ram_valid <= rd_en;
            abc_valid <= ram_valid; // one-cycle pulse, FMAs cannot stall it
            if (ram_valid) begin
                flags_out <= ram_flags; // held until the next WRITEB lands
            end
        end
    end

    // line is registered with its flags and then held
    always_ff @(posedge clk_in) begin
        if (ram_valid) begin
            abc_out <= rd_line;
        end
    end

endmodule

//--- source/line_ram.sv
module line_ram (
    input  logic                    clk_in,
    input  logic                    wr_en,
    input  mem_cfg_pkg::line_addr_t wr_addr,
    input  mem_cfg_pkg::line_t      wr_line,
    input  logic                    rd_en,
    input  mem_cfg_pkg::line_addr_t rd_addr,
    output mem_cfg_pkg::line_t      rd_line
);

    // contents are unknown after power up, lines must be written before they are read
    mem_cfg_pkg::line_t mem [mem_cfg_pkg::LINE_DEPTH];

    // --------------------------------------------------
    // write side
    // --------------------------------------------------

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_line; // whole line at once, no byte enables
        end
    end

    // --------------------------------------------------
    // read side
    // --------------------------------------------------

    // registered output holds the last line read until the next rd_en
    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            rd_line <= mem[rd_addr];
        end
    end

    // the handshake spacing keeps a read and a write from landing on the same edge

endmodule

//--- source/line_builder.sv
module line_builder (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  isa_pkg::mem_cmd_t       cmd,
    input  logic                    cmd_strobe,
    input  mem_cfg_pkg::line_t      wb_line,
    output logic                    wr_en,
    output mem_cfg_pkg::line_addr_t wr_addr,
    output mem_cfg_pkg::line_t      wr_line
);

    mem_cfg_pkg::line_t stage;      // staging line filled by LOADI and LOAD
    mem_cfg_pkg::line_t stage_next;
    mem_cfg_pkg::line_t wb_q;       // write buffer line one edge late

    // lowest bit of word k, counted from the top of the line
    function automatic int word_lsb(input int k);
        return mem_cfg_pkg::LINE_WIDTH - (k + 1) * mem_cfg_pkg::WORD_WIDTH;
    endfunction

    // --------------------------------------------------
    // staging line update
    // --------------------------------------------------

    always_comb begin
        stage_next = stage;
        if (cmd_strobe) begin
            case (cmd.op)
                isa_pkg::LOADI: begin
                    // loop only covers real words, so indices 6 to 15 match nothing
                    for (int k = 0; k < mem_cfg_pkg::WORDS_PER_LINE; k++) begin
                        if (cmd.field_a == isa_pkg::field_t'(k)) begin
                            stage_next[word_lsb(k) +: mem_cfg_pkg::WORD_WIDTH] = cmd.imm;
                        end
                    end
                end
                isa_pkg::LOAD: begin
                    // FMA i gets base + i * diff in the chosen slot, wrapping at 16 bits
                    for (int i = 0; i < mem_cfg_pkg::FMA_COUNT; i++) begin
                        for (int s = 0; s < mem_cfg_pkg::SLOTS_PER_FMA; s++) begin
                            if (cmd.field_a == isa_pkg::field_t'(s)) begin
                                stage_next[word_lsb(i * mem_cfg_pkg::SLOTS_PER_FMA + s)
                                           +: mem_cfg_pkg::WORD_WIDTH] =
                                    cmd.base + mem_cfg_pkg::word_t'(i) * cmd.imm;
                            end
                        end
                    end
                end
                default: begin
                    // every other opcode leaves the staging line alone
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stage <= '0;
        end else begin
            stage <= stage_next;
        end
    end

    // --------------------------------------------------
    // RAM write request
    // --------------------------------------------------

    // sampled every cycle so the strobe cycle sees the line from the accepting edge
    always_ff @(posedge clk_in) begin
        wb_q <= wb_line;
    end

    // the registered command is the write request, the RAM takes it on the next edge
    assign wr_en   = cmd_strobe && (cmd.op == isa_pkg::SENDL || cmd.op == isa_pkg::LOADB);
    assign wr_addr = cmd.addr;
    assign wr_line = (cmd.op == isa_pkg::LOADB) ? wb_q : stage; // SENDL sends the staging line

endmodule

//--- source/instr_port.sv
module instr_port (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  isa_pkg::instr_t         instr,
    input  logic                    instr_req,
    output logic                    instr_ack,
    input  mem_cfg_pkg::ctrl_regs_t regs,
    output isa_pkg::mem_cmd_t       cmd,
    output logic                    cmd_strobe
);

    // ACKED lasts exactly one cycle and doubles as the command strobe
    typedef enum logic [1:0] {
        IDLE,
        ACKED,
        WAIT_DROP
    } handshake_state_e;

    handshake_state_e        state;
    mem_cfg_pkg::line_addr_t cur_addr; // line address kept between instructions

    isa_pkg::opcode_e        op_f;
    isa_pkg::field_t         field_a_f;
    isa_pkg::field_t         field_b_f;
    mem_cfg_pkg::word_t      imm_f;
    mem_cfg_pkg::line_addr_t addr_f;   // address this instruction works on
    mem_cfg_pkg::word_t      base_f;
    mem_cfg_pkg::fma_flags_t flags_f;
    logic                    accept;

    // --------------------------------------------------
    // field decode
    // --------------------------------------------------

    always_comb begin
        // opcodes 11, 12, 14 and 15 fall into no case below and so do nothing
        op_f      = isa_pkg::opcode_e'(instr[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_WIDTH]);
        field_a_f = instr[isa_pkg::FIELD_A_LSB +: isa_pkg::FIELD_WIDTH];
        imm_f     = instr[isa_pkg::IMM_LSB +: isa_pkg::IMM_WIDTH];
        field_b_f = instr[isa_pkg::FIELD_B_LSB +: isa_pkg::FIELD_WIDTH];

        // only the low address bits of the immediate are used
        case (op_f)
            isa_pkg::SMA,
            isa_pkg::LOADB,
            isa_pkg::WRITEB: addr_f = imm_f[mem_cfg_pkg::ADDR_WIDTH-1:0];
            default:         addr_f = cur_addr; // SENDL and LOAD reuse the SMA address
        endcase

        case (field_b_f)
            isa_pkg::SEL_REG_A: base_f = regs.reg_a;
            isa_pkg::SEL_REG_B: base_f = regs.reg_b;
            default:            base_f = regs.reg_c;
        endcase

        flags_f.use_new_c = (field_a_f == isa_pkg::FIELD_SET); // other values read as false
        flags_f.fma_valid = (field_b_f == isa_pkg::FIELD_SET);
    end

    // a new request is only taken while ack is low
    assign accept = (state == IDLE) && instr_req;

    // --------------------------------------------------
    // four-phase handshake
    // --------------------------------------------------

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state    <= IDLE;
            cur_addr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (instr_req) begin
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    state <= WAIT_DROP; // command goes out during this cycle
                end
                WAIT_DROP: begin
                    if (!instr_req) begin
                        state <= IDLE; // ack falls together with this step
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            if (accept) begin
                cur_addr <= addr_f;
            end
        end
    end

    // command fields are captured once, on the accepting edge
    always_ff @(posedge clk_in) begin
        if (accept) begin
            cmd.op      <= op_f;
            cmd.addr    <= addr_f;
            cmd.field_a <= field_a_f;
            cmd.imm     <= imm_f;
            cmd.base    <= base_f; // regs as seen on the accepting edge
            cmd.flags   <= flags_f;
        end
    end

    assign instr_ack  = (state != IDLE);
    assign cmd_strobe = (state == ACKED);

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

    // --------------------------------------------------
    // instruction word layout
    // --------------------------------------------------
    // | 31..28 opcode | 27..24 field_a | 23..8 imm | 7..4 field_b | 3..0 unused |

    localparam int INSTR_WIDTH   = 32;
    localparam int OPCODE_WIDTH  = 4;
    localparam int FIELD_WIDTH   = 4;
    localparam int IMM_WIDTH     = mem_cfg_pkg::WORD_WIDTH;
    localparam int OPCODE_LSB    = 28;
    localparam int FIELD_A_LSB   = 24;
    localparam int IMM_LSB       = 8;
    localparam int FIELD_B_LSB   = 4;

    typedef logic [INSTR_WIDTH-1:0] instr_t;
    typedef logic [FIELD_WIDTH-1:0] field_t;

    // field_b values that select a controller register for LOAD, anything else picks reg_c
    localparam field_t SEL_REG_A = 4'd0;
    localparam field_t SEL_REG_B = 4'd1;

    // a WRITEB flag field is true only when it holds exactly this value
    localparam field_t FIELD_SET = 4'd1;

    // the ALU opcodes belong to the controller and pass through here with no effect
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP    = 4'd0,
        END    = 4'd1,
        XOR    = 4'd2,
        ADDI   = 4'd3,
        BGE    = 4'd4,
        JUMP   = 4'd5,
        SMA    = 4'd6,  // set the current line address
        LOADI  = 4'd7,  // immediate into one staging word
        SENDL  = 4'd8,  // staging line into the RAM
        LOADB  = 4'd9,  // write buffer line into the RAM
        WRITEB = 4'd10, // RAM line out to the FMAs
        LOAD   = 4'd13  // register plus per-FMA step into one slot of every FMA
    } opcode_e;

    // decoded instruction as handed to the datapath blocks
    typedef struct packed {
        opcode_e                 op;
        mem_cfg_pkg::line_addr_t addr;    // effective line address
        field_t                  field_a; // word index or slot
        mem_cfg_pkg::word_t      imm;     // value for LOADI, diff for LOAD
        mem_cfg_pkg::word_t      base;    // controller register picked by field_b
        mem_cfg_pkg::fma_flags_t flags;   // only meaningful for WRITEB
    } mem_cmd_t;

endpackage

//--- source/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // --------------------------------------------------
    // array geometry
    // --------------------------------------------------

    localparam int FMA_COUNT      = 2;  // FMAs fed from one line
    localparam int SLOTS_PER_FMA  = 3;  // a, b and c for each FMA
    localparam int WORD_WIDTH     = 16; // one operand
    localparam int WORDS_PER_LINE = FMA_COUNT * SLOTS_PER_FMA;   // 6 words
    localparam int LINE_WIDTH     = WORDS_PER_LINE * WORD_WIDTH; // 96 bits

    // 375 lines would do, the depth is rounded up so any 9-bit address is legal
    localparam int LINE_DEPTH = 512;
    localparam int ADDR_WIDTH = $clog2(LINE_DEPTH);

    // --------------------------------------------------
    // data types
    // --------------------------------------------------

    typedef logic [WORD_WIDTH-1:0] word_t;

    // word 0 sits in the top bits, word k feeds FMA k/3 at slot k mod 3
    typedef logic [LINE_WIDTH-1:0] line_t;

    typedef logic [ADDR_WIDTH-1:0] line_addr_t;

    // the three controller registers a LOAD may pick its base value from
    typedef struct packed {
        word_t reg_a;
        word_t reg_b;
        word_t reg_c;
    } ctrl_regs_t;

    // flags that travel with every line sent to the FMAs
    typedef struct packed {
        logic use_new_c; // FMAs take c from the line instead of their accumulator
        logic fma_valid; // FMAs may present their result
    } fma_flags_t;

endpackage
